// File: src/dcache_pkg.sv
// dcache package with widths, address field types and controller state codes
package dcache_pkg;

    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int MASK_W   = 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SETS     = 1 << INDEX_W;

    // controller states
    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE   = 2'd0;
    localparam logic [STATE_W-1:0] ST_LOOKUP = 2'd1;
    localparam logic [STATE_W-1:0] ST_WBACK  = 2'd2;
    localparam logic [STATE_W-1:0] ST_FILL   = 2'd3;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [MASK_W-1:0]   mask_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // tag in the upper bits and byte offset at the bottom
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_fields_t;

    // same 64 bits seen flat or split into fields
    typedef union packed {
        addr_t        flat;
        addr_fields_t f;
    } addr_u;

    // 0 names way 0 and 1 names way 1
    typedef logic way_sel_t;

endpackage

// File: src/dcache_lru.sv
// dcache LRU keeping one bit per set that names the least recently used way
module dcache_lru import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  index_t   index_i,
    input  logic     touch_i,
    input  way_sel_t touch_way_i,
    output way_sel_t victim_o
);

    logic [SETS-1:0] lru_q;

    assign victim_o = lru_q[index_i];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lru_q <= '0;
        end else if (touch_i) begin
            // the way not touched becomes the older one
            lru_q[index_i] <= ~touch_way_i;
        end
    end

endmodule

// File: src/dcache_way.sv
// dcache way holding the valid, dirty, tag and data arrays of one way with byte-masked writes
module dcache_way import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  index_t index_i,
    input  tag_t   tag_i,
    input  logic   wr_en_i,
    input  mask_t  wr_mask_i,
    input  data_t  wr_data_i,
    input  logic   fill_i,
    output logic   hit_o,
    output logic   valid_o,
    output logic   dirty_o,
    output tag_t   tag_o,
    output data_t  data_o
);

    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    tag_t            tag_q  [SETS];
    data_t           data_q [SETS];

    // lookups are combinational on the index
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign tag_o   = tag_q[index_i];
    assign data_o  = data_q[index_i];
    assign hit_o   = valid_q[index_i] && (tag_q[index_i] == tag_i);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en_i) begin
            if (fill_i) begin
                // fresh line from memory is clean
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= 1'b0;
            end else begin
                dirty_q[index_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i && fill_i) begin
            tag_q[index_i] <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (wr_mask_i[b]) begin
                    data_q[index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: src/dcache_ctrl.sv
// dcache controller FSM for lookup, write-back and refill with CPU and memory handshakes
module dcache_ctrl import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_i,
    input  logic       we_i,
    input  addr_t      addr_i,
    input  data_t      wdata_i,
    input  mask_t      mask_i,
    output logic       done_o,
    output data_t      rdata_o,
    output logic       mem_req_o,
    output logic       mem_we_o,
    output addr_t      mem_addr_o,
    output data_t      mem_wdata_o,
    input  logic       mem_ok_i,
    input  data_t      mem_rdata_i,
    output index_t     index_o,
    output tag_t       tag_o,
    output logic [1:0] wr_en_o,
    output mask_t      wr_mask_o,
    output data_t      wr_data_o,
    output logic       fill_o,
    input  logic [1:0] hit_i,
    input  logic [1:0] valid_i,
    input  logic [1:0] dirty_i,
    input  tag_t       way_tag0_i,
    input  tag_t       way_tag1_i,
    input  data_t      way_data0_i,
    input  data_t      way_data1_i,
    output logic       touch_o,
    output way_sel_t   touch_way_o,
    input  way_sel_t   victim_i
);

    logic [STATE_W-1:0] state_q;
    logic [STATE_W-1:0] state_d;
    addr_u    req_q;
    logic     we_q;
    data_t    wdata_q;
    mask_t    mask_q;
    way_sel_t fill_way_q;
    logic     hit_any;
    way_sel_t victim;
    logic     victim_dirty;
    logic     start_wb;
    logic     start_fill;
    addr_u    wb_addr;
    addr_u    fill_addr;

    assign index_o = req_q.f.index;
    assign tag_o   = req_q.f.tag;
    assign hit_any = |hit_i;

    // an empty way is taken before the LRU choice
    assign victim       = !valid_i[0] ? 1'b0 : (!valid_i[1] ? 1'b1 : victim_i);
    assign victim_dirty = valid_i[victim] & dirty_i[victim];

    assign start_wb   = (state_q == ST_LOOKUP) && !hit_any && victim_dirty;
    assign start_fill = ((state_q == ST_LOOKUP) && !hit_any && !victim_dirty) ||
                        ((state_q == ST_WBACK) && mem_ok_i);

    always_comb begin
        wb_addr.f.tag      = victim ? way_tag1_i : way_tag0_i;
        wb_addr.f.index    = req_q.f.index;
        wb_addr.f.offset   = '0;
        fill_addr.flat     = req_q.flat;
        fill_addr.f.offset = '0;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (req_i) state_d = ST_LOOKUP;
            ST_LOOKUP: state_d = hit_any ? ST_IDLE : (victim_dirty ? ST_WBACK : ST_FILL);
            ST_WBACK:  if (mem_ok_i) state_d = ST_FILL;
            ST_FILL:   if (mem_ok_i) state_d = ST_LOOKUP;
            default:   state_d = ST_IDLE;
        endcase
    end

    // store hits merge under the CPU mask and refills write the whole word
    always_comb begin
        wr_en_o   = '0;
        wr_mask_o = mask_q;
        wr_data_o = wdata_q;
        fill_o    = 1'b0;
        if ((state_q == ST_LOOKUP) && we_q) begin
            wr_en_o = hit_i;
        end else if ((state_q == ST_FILL) && mem_ok_i) begin
            wr_en_o[fill_way_q] = 1'b1;
            wr_mask_o           = '1;
            wr_data_o           = mem_rdata_i;
            fill_o              = 1'b1;
        end
    end

    assign touch_o     = (state_q == ST_LOOKUP) && hit_any;
    assign touch_way_o = hit_i[1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q   <= ST_IDLE;
            done_o    <= 1'b0;
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
        end else begin
            state_q   <= state_d;
            done_o    <= (state_q == ST_LOOKUP) && hit_any;
            mem_req_o <= start_wb || start_fill;
            if (start_wb) begin
                mem_we_o <= 1'b1;
            end else if (start_fill) begin
                mem_we_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && req_i) begin
            req_q.flat <= addr_i;
            we_q       <= we_i;
            wdata_q    <= wdata_i;
            mask_q     <= mask_i;
        end
        if ((state_q == ST_LOOKUP) && hit_any && !we_q) begin
            rdata_o <= hit_i[1] ? way_data1_i : way_data0_i;
        end
        if ((state_q == ST_LOOKUP) && !hit_any) begin
            fill_way_q <= victim;
        end
        if (start_wb) begin
            mem_addr_o  <= wb_addr.flat;
            mem_wdata_o <= victim ? way_data1_i : way_data0_i;
        end else if (start_fill) begin
            mem_addr_o  <= fill_addr.flat;
        end
    end

endmodule

// File: src/dcache_top.sv
// dcache top level building a two-way write-back data cache from controller, ways and LRU
module dcache_top import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_i,
    input  logic     we_i,
    input  addr_t    addr_i,
    input  data_t    wdata_i,
    input  mask_t    mask_i,
    output logic     done_o,
    output data_t    rdata_o,
    output logic     mem_req_o,
    output logic     mem_we_o,
    output addr_t    mem_addr_o,
    output data_t    mem_wdata_o,
    input  logic     mem_ok_i,
    input  data_t    mem_rdata_i
);

    index_t   index;
    tag_t     tag;
    logic [1:0] wr_en;
    mask_t    wr_mask;
    data_t    wr_data;
    logic     fill;
    logic [1:0] hit;
    logic [1:0] valid;
    logic [1:0] dirty;
    tag_t     way_tag0;
    tag_t     way_tag1;
    data_t    way_data0;
    data_t    way_data1;
    logic     touch;
    way_sel_t touch_way;
    way_sel_t victim;

    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .req_i(req_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i), .mask_i(mask_i),
        .done_o(done_o), .rdata_o(rdata_o),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_ok_i(mem_ok_i), .mem_rdata_i(mem_rdata_i),
        .index_o(index), .tag_o(tag),
        .wr_en_o(wr_en), .wr_mask_o(wr_mask), .wr_data_o(wr_data), .fill_o(fill),
        .hit_i(hit), .valid_i(valid), .dirty_i(dirty),
        .way_tag0_i(way_tag0), .way_tag1_i(way_tag1),
        .way_data0_i(way_data0), .way_data1_i(way_data1),
        .touch_o(touch), .touch_way_o(touch_way), .victim_i(victim)
    );

    dcache_way u_way0 (
        .clk(clk), .rst(rst), .index_i(index), .tag_i(tag),
        .wr_en_i(wr_en[0]), .wr_mask_i(wr_mask), .wr_data_i(wr_data), .fill_i(fill),
        .hit_o(hit[0]), .valid_o(valid[0]), .dirty_o(dirty[0]),
        .tag_o(way_tag0), .data_o(way_data0)
    );

    dcache_way u_way1 (
        .clk(clk), .rst(rst), .index_i(index), .tag_i(tag),
        .wr_en_i(wr_en[1]), .wr_mask_i(wr_mask), .wr_data_i(wr_data), .fill_i(fill),
        .hit_o(hit[1]), .valid_o(valid[1]), .dirty_o(dirty[1]),
        .tag_o(way_tag1), .data_o(way_data1)
    );

    dcache_lru u_lru (
        .clk(clk), .rst(rst), .index_i(index),
        .touch_i(touch), .touch_way_i(touch_way), .victim_o(victim)
    );

endmodule

// File: testbench/tb_mem_model.sv
// backing memory model that answers cache requests from a sparse word store after a random delay
module tb_mem_model import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_req_i,
    input  logic  mem_we_i,
    input  addr_t mem_addr_i,
    input  data_t mem_wdata_i,
    output logic  mem_ok_o,
    output data_t mem_rdata_o
);

    // words never written read back as zero
    data_t store [addr_t];

    initial begin
        int unsigned delay;
        addr_t       req_addr;
        logic        req_we;
        data_t       req_wdata;
        mem_ok_o    = 1'b0;
        mem_rdata_o = '0;
        forever begin
            @(posedge clk);
            if (rst && mem_req_i) begin
                req_addr  = mem_addr_i;
                req_we    = mem_we_i;
                req_wdata = mem_wdata_i;
                delay     = $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk);
                if (req_we) begin
                    store[req_addr] = req_wdata;
                end else begin
                    mem_rdata_o <= store.exists(req_addr) ? store[req_addr] : '0;
                end
                mem_ok_o <= 1'b1;
                @(posedge clk);
                mem_ok_o <= 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_dcache.sv
// dcache testbench running table-driven and random accesses against a shadow memory
module tb_dcache import dcache_pkg::*; ();

    localparam int N_TABLE      = 12;
    localparam int N_RAND       = 40;
    localparam int WATCH_CYCLES = (N_TABLE + N_RAND + 2) * 20;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t wdata;
        mask_t mask;
        logic  exp_hit;
        logic  exp_wb;
        addr_t wb_addr;
    } stim_t;

    logic  clk;
    logic  rst;
    logic  req_i;
    logic  we_i;
    addr_t addr_i;
    data_t wdata_i;
    mask_t mask_i;
    logic  done_o;
    data_t rdata_o;
    logic  mem_req_o;
    logic  mem_we_o;
    addr_t mem_addr_o;
    data_t mem_wdata_o;
    logic  mem_ok_i;
    data_t mem_rdata_i;

    stim_t stim_q [$];
    string name_q [$];
    data_t shadow [addr_t];

    dcache_top UUT (
        .clk(clk), .rst(rst), .req_i(req_i), .we_i(we_i), .addr_i(addr_i),
        .wdata_i(wdata_i), .mask_i(mask_i), .done_o(done_o), .rdata_o(rdata_o),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_ok_i(mem_ok_i), .mem_rdata_i(mem_rdata_i)
    );

    tb_mem_model u_mem (
        .clk(clk), .rst(rst), .mem_req_i(mem_req_o), .mem_we_i(mem_we_o),
        .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o),
        .mem_ok_o(mem_ok_i), .mem_rdata_o(mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s expected %0d cycles actual %0d cycles", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    function automatic void add_entry(input string name, input logic we, input addr_t addr,
            input data_t wdata, input mask_t mask, input logic exp_hit, input logic exp_wb,
            input addr_t wb_addr);
        name_q.push_back(name);
        stim_q.push_back(stim_t'{we, addr, wdata, mask, exp_hit, exp_wb, wb_addr});
    endfunction

    function automatic data_t shadow_read(input addr_t addr);
        addr_t key;
        key = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        return shadow.exists(key) ? shadow[key] : '0;
    endfunction

    // a store only changes the bytes selected by its mask
    function automatic void shadow_write(input addr_t addr, input data_t wdata, input mask_t mask);
        data_t word;
        word = shadow_read(addr);
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                word[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        shadow[{addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}] = word;
    endfunction

    // latency counts clock edges from the one that samples req_i to the one that sees done_o
    task automatic run_access(input logic we, input addr_t addr, input data_t wdata,
            input mask_t mask, output data_t rdata, output int lat, output logic mem_seen,
            output logic wb_seen, output addr_t wb_addr, output data_t wb_data);
        logic seen_done;
        @(posedge clk);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        wdata_i <= wdata;
        mask_i  <= mask;
        @(posedge clk);
        req_i     <= 1'b0;
        lat       = 0;
        mem_seen  = 1'b0;
        wb_seen   = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        rdata     = '0;
        seen_done = 1'b0;
        while (!seen_done) begin
            @(negedge clk);
            if (mem_req_o) begin
                mem_seen = 1'b1;
                if (mem_we_o) begin
                    wb_seen = 1'b1;
                    wb_addr = mem_addr_o;
                    wb_data = mem_wdata_o;
                end
            end
            if (done_o) begin
                seen_done = 1'b1;
                rdata     = rdata_o;
            end
            @(posedge clk);
            lat++;
        end
    endtask

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout: the cache stopped answering requests");
        stop_on_error();
    end

    initial begin
        stim_t s;
        string name;
        data_t rdata;
        data_t wb_data;
        data_t exp_word;
        data_t r_data;
        addr_t wb_addr;
        addr_t r_addr;
        mask_t r_mask;
        logic  r_we;
        logic  mem_seen;
        logic  wb_seen;
        int    lat;
        int unsigned sel;
        void'($urandom(5657));
        rst     = 1'b0;
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        mask_i  = '0;
        // 0x208, 0x408 and 0x608 share set 1 with tags 1, 2 and 3
        add_entry("store_a_low", 1'b1, 64'h208, 64'h1111_2222_3333_4444, 8'h0f,
                  1'b0, 1'b0, '0);
        add_entry("read_a", 1'b0, 64'h208, '0, '0, 1'b1, 1'b0, '0);
        add_entry("store_a_high", 1'b1, 64'h208, 64'haaaa_bbbb_cccc_dddd, 8'hf0,
                  1'b1, 1'b0, '0);
        add_entry("read_a_merged", 1'b0, 64'h208, '0, '0, 1'b1, 1'b0, '0);
        add_entry("store_b", 1'b1, 64'h408, 64'h5555_6666_7777_8888, 8'hff,
                  1'b0, 1'b0, '0);
        add_entry("read_b", 1'b0, 64'h408, '0, '0, 1'b1, 1'b0, '0);
        add_entry("read_c_evict_a", 1'b0, 64'h608, '0, '0, 1'b0, 1'b1, 64'h208);
        add_entry("read_a_evict_b", 1'b0, 64'h208, '0, '0, 1'b0, 1'b1, 64'h408);
        add_entry("read_b_refill", 1'b0, 64'h408, '0, '0, 1'b0, 1'b0, '0);
        add_entry("read_a_resident", 1'b0, 64'h208, '0, '0, 1'b1, 1'b0, '0);
        add_entry("store_d", 1'b1, 64'h1000_0010, 64'h0123_4567_89ab_cdef, 8'h3c,
                  1'b0, 1'b0, '0);
        add_entry("read_d", 1'b0, 64'h1000_0014, '0, '0, 1'b1, 1'b0, '0);
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_flag("idle_done", 1'b0, done_o);
            check_flag("idle_mem_req", 1'b0, mem_req_o);
        end
        for (int i = 0; i < stim_q.size(); i++) begin
            s        = stim_q[i];
            name     = name_q[i];
            exp_word = shadow_read(s.addr);
            run_access(s.we, s.addr, s.wdata, s.mask, rdata, lat, mem_seen, wb_seen,
                       wb_addr, wb_data);
            check_flag({name, "_hit"}, s.exp_hit, !mem_seen);
            if (s.exp_hit) begin
                check_latency({name, "_latency"}, 2, lat);
            end
            check_flag({name, "_writeback"}, s.exp_wb, wb_seen);
            if (s.exp_wb) begin
                check_addr({name, "_wb_addr"}, s.wb_addr, wb_addr);
                check_data({name, "_wb_data"}, shadow_read(s.wb_addr), wb_data);
            end
            if (s.we) begin
                shadow_write(s.addr, s.wdata, s.mask);
            end else begin
                check_data({name, "_rdata"}, exp_word, rdata);
            end
        end
        // four tags over two sets keeps evictions frequent
        for (int n = 0; n < N_RAND; n++) begin
            sel      = $urandom_range(7, 0);
            r_addr   = ((addr_t'(sel % 4) + 64'd1) << 9) | (addr_t'(sel / 4) << 3);
            r_addr   = r_addr | addr_t'($urandom_range(7, 0));
            r_we     = ($urandom % 2) == 1;
            r_data   = {$urandom, $urandom};
            r_mask   = mask_t'($urandom_range(255, 1));
            exp_word = shadow_read(r_addr);
            run_access(r_we, r_addr, r_data, r_mask, rdata, lat, mem_seen, wb_seen,
                       wb_addr, wb_data);
            if (r_we) begin
                shadow_write(r_addr, r_data, r_mask);
            end else begin
                check_data($sformatf("random_%0d_rdata", n), exp_word, rdata);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: files.f
src/dcache_pkg.sv
src/dcache_lru.sv
src/dcache_way.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dcache -f files.f -o sim_dcache \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || echo "build or simulation returned an error" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
